// File: design/vrc6_settings.svh
//***************************************************************************
// vrc6 settings: widths, prescaler reloads and register counts shared by
// the mapper, its sound channels and the testbench
//***************************************************************************

`ifndef VRC6_SETTINGS_SVH
`define VRC6_SETTINGS_SVH

// bank numbers
`define VRC6_PRG_BANK_W 6   // 8 KiB PRG banks
`define VRC6_CHR_BANK_W 8   // 1 KiB CHR banks
`define VRC6_CHR_REGS 8

// scanline prescaler, reloads 113, 113, 112
`define VRC6_SCALER_W 7
`define VRC6_SCALER_LONG 7'd113
`define VRC6_SCALER_SHORT 7'd112

// sound channels
`define VRC6_FREQ_W 12
`define VRC6_SAW_RATE_W 6
`define VRC6_SAW_STEPS 7
`define VRC6_PULSE_W 4
`define VRC6_SAW_W 5
`define VRC6_MIX_W 6        // 0 to 0x3D

`endif

// File: design/vrc6_cpu_pkg.sv
//***************************************************************************
// vrc6 cpu package: writable register selects and bank number types
//***************************************************************************
`default_nettype none

`include "vrc6_settings.svh"

package vrc6_cpu_pkg;

    // one value per register the CPU can write
    typedef enum logic [4:0] {
        REG_NONE,
        REG_PRG_8000,
        REG_PRG_C000,
        REG_MIRROR,      // B003
        REG_CHR0,        // D000..D003, then E000..E003, kept in order
        REG_CHR1,
        REG_CHR2,
        REG_CHR3,
        REG_CHR4,
        REG_CHR5,
        REG_CHR6,
        REG_CHR7,
        REG_IRQ_LATCH,   // F000
        REG_IRQ_CTRL,    // F001
        REG_IRQ_ACK,     // F002
        REG_PULSE0_CTRL, // 9000..9002
        REG_PULSE0_FLO,
        REG_PULSE0_FHI,
        REG_PULSE1_CTRL, // A000..A002
        REG_PULSE1_FLO,
        REG_PULSE1_FHI,
        REG_SAW_RATE,    // B000..B002
        REG_SAW_FLO,
        REG_SAW_FHI
    } reg_sel_e;

    typedef logic [`VRC6_PRG_BANK_W-1:0] prg_bank_t;
    typedef logic [`VRC6_CHR_BANK_W-1:0] chr_bank_t;

endpackage

`default_nettype wire

// File: design/vrc6_audio_pkg.sv
//***************************************************************************
// vrc6 audio package: channel and mixed output levels
//***************************************************************************
`default_nettype none

`include "vrc6_settings.svh"

package vrc6_audio_pkg;

    // raw unsigned levels, no lookup or scaling applied
    typedef logic [`VRC6_PULSE_W-1:0] pulse_level_t;  // 0..0x0F
    typedef logic [`VRC6_SAW_W-1:0]   saw_level_t;    // 0..0x1F
    typedef logic [`VRC6_MIX_W-1:0]   mix_level_t;    // 0..0x3D

endpackage

`default_nettype wire

// File: design/vrc6_banking.sv
//***************************************************************************
// vrc6 banking: board variant address swap, register decode, PRG and CHR
// bank registers, masked bank addresses and nametable mirroring
//***************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vrc6_settings.svh"

module vrc6_banking (
    input  logic                    clk20,
    input  logic                    reset,
    input  logic                    ce,
    input  logic                    prg_we,
    input  logic                    swap_a01,
    input  logic [15:0]             prg_a,
    input  logic [13:0]             chr_a,
    input  logic [7:0]              data_in,
    input  vrc6_cpu_pkg::prg_bank_t prg_mask,
    input  logic [`VRC6_CHR_BANK_W-2:0] chr_mask,
    output vrc6_cpu_pkg::reg_sel_e  reg_sel,
    output logic                    reg_wr,
    output vrc6_cpu_pkg::prg_bank_t prg_addr,
    output logic [`VRC6_CHR_BANK_W:0] chr_addr,  // bits 18:10
    output logic                    ciram_ce
);

    logic [15:0]                   ain;
    logic [2:0]                    chr_idx;
    logic [`VRC6_PRG_BANK_W-2:0]   prg_8000;
    vrc6_cpu_pkg::prg_bank_t       prg_c000;
    vrc6_cpu_pkg::chr_bank_t       chr_bank [`VRC6_CHR_REGS];
    logic [1:0]                    mirror;
    vrc6_cpu_pkg::prg_bank_t       prg_bank;
    vrc6_cpu_pkg::chr_bank_t       cur_chr;
    logic                          ntb_a10;

    // mapper 26 boards have A0 and A1 crossed
    assign ain = swap_a01 ? {prg_a[15:2], prg_a[0], prg_a[1]} : prg_a;
    assign chr_idx = {~ain[12], ain[1:0]};  // Dxxx -> 0..3, Exxx -> 4..7

    always_comb begin
        casez ({ain[15:12], ain[1:0]})
            6'b1000??: reg_sel = vrc6_cpu_pkg::REG_PRG_8000;
            6'b100100: reg_sel = vrc6_cpu_pkg::REG_PULSE0_CTRL;
            6'b100101: reg_sel = vrc6_cpu_pkg::REG_PULSE0_FLO;
            6'b100110: reg_sel = vrc6_cpu_pkg::REG_PULSE0_FHI;
            6'b101000: reg_sel = vrc6_cpu_pkg::REG_PULSE1_CTRL;
            6'b101001: reg_sel = vrc6_cpu_pkg::REG_PULSE1_FLO;
            6'b101010: reg_sel = vrc6_cpu_pkg::REG_PULSE1_FHI;
            6'b101100: reg_sel = vrc6_cpu_pkg::REG_SAW_RATE;
            6'b101101: reg_sel = vrc6_cpu_pkg::REG_SAW_FLO;
            6'b101110: reg_sel = vrc6_cpu_pkg::REG_SAW_FHI;
            6'b101111: reg_sel = vrc6_cpu_pkg::REG_MIRROR;
            6'b1100??: reg_sel = vrc6_cpu_pkg::REG_PRG_C000;
            6'b1101??, 6'b1110??: begin
                reg_sel = vrc6_cpu_pkg::reg_sel_e'(5'(vrc6_cpu_pkg::REG_CHR0) + 5'(chr_idx));
            end
            6'b111100: reg_sel = vrc6_cpu_pkg::REG_IRQ_LATCH;
            6'b111101: reg_sel = vrc6_cpu_pkg::REG_IRQ_CTRL;
            6'b111110: reg_sel = vrc6_cpu_pkg::REG_IRQ_ACK;
            default:   reg_sel = vrc6_cpu_pkg::REG_NONE;
        endcase
    end

    assign reg_wr = ce & prg_we & (reg_sel != vrc6_cpu_pkg::REG_NONE);

    always_ff @(posedge clk20) begin
        if (reg_wr) begin
            if (reg_sel == vrc6_cpu_pkg::REG_PRG_8000) begin
                prg_8000 <= data_in[`VRC6_PRG_BANK_W-2:0];
            end
            if (reg_sel == vrc6_cpu_pkg::REG_PRG_C000) begin
                prg_c000 <= data_in[`VRC6_PRG_BANK_W-1:0];
            end
            if (reg_sel inside {[vrc6_cpu_pkg::REG_CHR0:vrc6_cpu_pkg::REG_CHR7]}) begin
                chr_bank[chr_idx] <= data_in;
            end
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            mirror <= 2'd0;  // vertical
        end else if (reg_wr && reg_sel == vrc6_cpu_pkg::REG_MIRROR) begin
            mirror <= data_in[3:2];
        end
    end

    always_comb begin
        casez (prg_a[15:13])
            3'b0??:  prg_bank = '0;                   // 6000-7FFF work RAM
            3'b10?:  prg_bank = {prg_8000, prg_a[13]};  // 16 KiB window
            3'b110:  prg_bank = prg_c000;
            default: prg_bank = '1;                   // fixed last bank
        endcase
    end

    assign prg_addr = prg_bank & prg_mask;

    // nametable select
    always_comb begin
        case (mirror)
            2'd0:    ntb_a10 = chr_a[10];
            2'd1:    ntb_a10 = chr_a[11];
            2'd2:    ntb_a10 = 1'b0;
            default: ntb_a10 = 1'b1;
        endcase
    end

    assign cur_chr  = chr_bank[chr_a[12:10]];
    assign ciram_ce = chr_a[13];
    assign chr_addr = {{1'b0, cur_chr[`VRC6_CHR_BANK_W-1:2]} & chr_mask,
                       cur_chr[1],
                       chr_a[13] ? ntb_a10 : cur_chr[0]};

    // registers only decode in 8000-FFFF
    a_wr_upper_half: assert property (@(posedge clk20) disable iff (reset)
        reg_wr |-> prg_a[15]);

endmodule

`default_nettype wire

// File: design/vrc6_irq.sv
//***************************************************************************
// vrc6 irq: latch, 8-bit up counter and scanline prescaler, timeout on
// counter overflow, enable handling on control and acknowledge writes
//***************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vrc6_settings.svh"

module vrc6_irq (
    input  logic                   clk20,
    input  logic                   reset,
    input  logic                   ce,
    input  logic                   reg_wr,
    input  vrc6_cpu_pkg::reg_sel_e reg_sel,
    input  logic [7:0]             data_in,
    output logic                   irq
);

    logic [7:0]                latch;
    logic [7:0]                counter;
    logic [`VRC6_SCALER_W-1:0] scaler;
    logic [1:0]                line;
    logic                      cycle_mode;
    logic                      ack_enable;  // enable restored on acknowledge
    logic                      enable;
    logic                      timeout;
    logic                      ctrl_wr;
    logic                      ack_wr;
    logic                      tick;

    assign ctrl_wr = reg_wr && reg_sel == vrc6_cpu_pkg::REG_IRQ_CTRL;
    assign ack_wr  = reg_wr && reg_sel == vrc6_cpu_pkg::REG_IRQ_ACK;
    assign tick    = ce && enable && (cycle_mode || scaler == '0);

    always_ff @(posedge clk20) begin
        if (reg_wr && reg_sel == vrc6_cpu_pkg::REG_IRQ_LATCH) begin
            latch <= data_in;
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            counter    <= 8'd0;
            scaler     <= '0;
            line       <= 2'd0;
            cycle_mode <= 1'b0;
            ack_enable <= 1'b0;
            enable     <= 1'b0;
            timeout    <= 1'b0;
        end else if (ctrl_wr) begin
            {cycle_mode, enable, ack_enable} <= data_in[2:0];
            timeout <= 1'b0;
            if (data_in[1]) begin
                counter <= latch;
                scaler  <= `VRC6_SCALER_LONG;
                line    <= 2'd0;
            end
        end else begin
            if (ack_wr) begin
                timeout <= 1'b0;
                enable  <= ack_enable;
            end else if (tick && counter == 8'hff) begin
                timeout <= 1'b1;
            end
            // 341 PPU dots per line is 113.67 CPU cycles
            if (ce && enable) begin
                if (scaler != '0) begin
                    scaler <= scaler - 1'b1;
                end else begin
                    scaler <= line[1] ? `VRC6_SCALER_SHORT : `VRC6_SCALER_LONG;
                    line   <= line[1] ? 2'd0 : line + 2'd1;
                end
            end
            if (tick) begin
                counter <= (counter == 8'hff) ? latch : counter + 8'd1;
            end
        end
    end

    assign irq = timeout & enable;

    // prescaler stays inside its reload range
    a_scaler_range: assert property (@(posedge clk20) disable iff (reset)
        scaler <= `VRC6_SCALER_LONG && line != 2'd3);

endmodule

`default_nettype wire

// File: design/vrc6_pulse.sv
//***************************************************************************
// vrc6 pulse: one square channel with duty, volume, digitized mode and a
// 12-bit frequency divider stepping a 16-step duty counter
//***************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vrc6_settings.svh"

module vrc6_pulse #(
    parameter int CHANNEL = 0  // 0 answers at 9000, 1 at A000
) (
    input  logic                        clk20,
    input  logic                        reset,
    input  logic                        ce,
    input  logic                        reg_wr,
    input  vrc6_cpu_pkg::reg_sel_e      reg_sel,
    input  logic [7:0]                  data_in,
    output vrc6_audio_pkg::pulse_level_t level
);

    localparam vrc6_cpu_pkg::reg_sel_e SEL_CTRL =
        (CHANNEL == 0) ? vrc6_cpu_pkg::REG_PULSE0_CTRL : vrc6_cpu_pkg::REG_PULSE1_CTRL;
    localparam vrc6_cpu_pkg::reg_sel_e SEL_FLO =
        (CHANNEL == 0) ? vrc6_cpu_pkg::REG_PULSE0_FLO : vrc6_cpu_pkg::REG_PULSE1_FLO;
    localparam vrc6_cpu_pkg::reg_sel_e SEL_FHI =
        (CHANNEL == 0) ? vrc6_cpu_pkg::REG_PULSE0_FHI : vrc6_cpu_pkg::REG_PULSE1_FHI;

    logic                         mode;  // constant volume output
    logic [2:0]                   duty;
    vrc6_audio_pkg::pulse_level_t volume;
    logic [`VRC6_FREQ_W-1:0]      freq;
    logic [`VRC6_FREQ_W-1:0]      div;
    logic [3:0]                   step;
    logic                         enable;

    always_ff @(posedge clk20) begin
        if (reg_wr && reg_sel == SEL_CTRL) begin
            {mode, duty, volume} <= data_in;
        end
        if (reg_wr && reg_sel == SEL_FLO) begin
            freq[7:0] <= data_in;
        end
        if (reg_wr && reg_sel == SEL_FHI) begin
            freq[`VRC6_FREQ_W-1:8] <= data_in[3:0];
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable <= 1'b0;
            div    <= '0;
            step   <= 4'd0;
            level  <= '0;
        end else if (ce) begin
            if (reg_wr && reg_sel == SEL_FHI) begin
                enable <= data_in[7];
            end
            if (enable) begin
                if (div != '0) begin
                    div <= div - 1'b1;
                end else begin
                    div  <= freq;
                    step <= step + 4'd1;
                end
            end
            // high for steps 0..duty
            level <= (enable && (mode || step <= {1'b0, duty})) ? volume : '0;
        end
    end

endmodule

`default_nettype wire

// File: design/vrc6_saw.sv
//***************************************************************************
// vrc6 saw: sawtooth channel, rate added to an 8-bit accumulator on each
// divider step and cleared every seventh step
//***************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vrc6_settings.svh"

module vrc6_saw (
    input  logic                       clk20,
    input  logic                       reset,
    input  logic                       ce,
    input  logic                       reg_wr,
    input  vrc6_cpu_pkg::reg_sel_e     reg_sel,
    input  logic [7:0]                 data_in,
    output vrc6_audio_pkg::saw_level_t level
);

    logic [`VRC6_SAW_RATE_W-1:0] rate;
    logic [`VRC6_FREQ_W-1:0]     freq;
    logic [`VRC6_FREQ_W:0]       div;  // runs at half the pulse rate
    logic [2:0]                  step;
    logic [7:0]                  acc;
    logic                        enable;

    always_ff @(posedge clk20) begin
        if (reg_wr && reg_sel == vrc6_cpu_pkg::REG_SAW_RATE) begin
            rate <= data_in[`VRC6_SAW_RATE_W-1:0];
        end
        if (reg_wr && reg_sel == vrc6_cpu_pkg::REG_SAW_FLO) begin
            freq[7:0] <= data_in;
        end
        if (reg_wr && reg_sel == vrc6_cpu_pkg::REG_SAW_FHI) begin
            freq[`VRC6_FREQ_W-1:8] <= data_in[3:0];
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable <= 1'b0;
            div    <= '0;
            step   <= 3'd0;
            acc    <= 8'd0;
            level  <= '0;
        end else if (ce) begin
            if (reg_wr && reg_sel == vrc6_cpu_pkg::REG_SAW_FHI) begin
                enable <= data_in[7];
            end
            if (enable) begin
                if (div != '0) begin
                    div <= div - 1'b1;
                end else begin
                    div <= {freq, 1'b1};
                    if (step == 3'(`VRC6_SAW_STEPS - 1)) begin
                        step <= 3'd0;
                        acc  <= 8'd0;
                    end else begin
                        step <= step + 3'd1;
                        acc  <= acc + {2'b00, rate};
                    end
                end
            end
            level <= enable ? acc[7:3] : '0;
        end
    end

    a_step_bound: assert property (@(posedge clk20) disable iff (reset)
        step <= 3'(`VRC6_SAW_STEPS - 1));

endmodule

`default_nettype wire

// File: design/vrc6_mapper.sv
//***************************************************************************
// vrc6 mapper top: banking, scanline irq and the three expansion sound
// channels, summed into one raw level
//***************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vrc6_settings.svh"

module vrc6_mapper (
    input  logic                        clk20,
    input  logic                        reset,
    input  logic                        ce,
    input  logic                        prg_we,
    input  logic                        swap_a01,     // high for mapper 26
    input  logic [15:0]                 prg_a,
    input  logic [13:0]                 chr_a,
    input  logic [7:0]                  data_in,
    input  vrc6_cpu_pkg::prg_bank_t     prg_mask,
    input  logic [`VRC6_CHR_BANK_W-2:0] chr_mask,
    output vrc6_cpu_pkg::prg_bank_t     prg_addr,
    output logic [`VRC6_CHR_BANK_W:0]   chr_addr,
    output logic                        ciram_ce,
    output logic                        irq,
    output vrc6_audio_pkg::mix_level_t  audio_level
);

    vrc6_cpu_pkg::reg_sel_e       reg_sel;
    logic                         reg_wr;
    vrc6_audio_pkg::pulse_level_t pulse0_level;
    vrc6_audio_pkg::pulse_level_t pulse1_level;
    vrc6_audio_pkg::saw_level_t   saw_level;

    vrc6_banking u_banking (
        .clk20, .reset, .ce, .prg_we, .swap_a01, .prg_a, .chr_a, .data_in,
        .prg_mask, .chr_mask, .reg_sel, .reg_wr, .prg_addr, .chr_addr, .ciram_ce
    );

    vrc6_irq u_irq (
        .clk20, .reset, .ce, .reg_wr, .reg_sel, .data_in, .irq
    );

    vrc6_pulse #(.CHANNEL(0)) u_pulse0 (
        .clk20, .reset, .ce, .reg_wr, .reg_sel, .data_in, .level(pulse0_level)
    );

    vrc6_pulse #(.CHANNEL(1)) u_pulse1 (
        .clk20, .reset, .ce, .reg_wr, .reg_sel, .data_in, .level(pulse1_level)
    );

    vrc6_saw u_saw (
        .clk20, .reset, .ce, .reg_wr, .reg_sel, .data_in, .level(saw_level)
    );

    // max 0x0F + 0x0F + 0x1F, fits without saturation
    assign audio_level = vrc6_audio_pkg::mix_level_t'(pulse0_level)
                       + vrc6_audio_pkg::mix_level_t'(pulse1_level)
                       + vrc6_audio_pkg::mix_level_t'(saw_level);

endmodule

`default_nettype wire

// File: dv/vrc6_tb.sv
//***************************************************************************
// vrc6 testbench: drives the mapper top through banking, mirroring, irq
// and sound scenarios, with concurrent assertions doing the checks
//***************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vrc6_settings.svh"

module vrc6_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int SEED         = 32'h5f51;
    // cycle budget per test, summed for the watchdog
    localparam int RESET_CYC    = 10;
    localparam int PRG_CYC      = 80;
    localparam int CHR_CYC      = 150;
    localparam int IRQ_CYC      = 560;
    localparam int PULSE_CYC    = 80;
    localparam int SAW_CYC      = 140;
    localparam int MARGIN_CYC   = 200;
    localparam int WATCHDOG_CYC = RESET_CYC + PRG_CYC + CHR_CYC + IRQ_CYC
                                + PULSE_CYC + SAW_CYC + MARGIN_CYC;
    localparam int SAW_STEP_CYC = 2;  // divider reload 2*0+1 at frequency 0
    localparam int ZERO_GAP     = 14 * SAW_STEP_CYC;

    logic                        clk20;
    logic                        reset;
    logic                        ce;
    logic                        prg_we;
    logic                        swap_a01;
    logic [15:0]                 prg_a;
    logic [13:0]                 chr_a;
    logic [7:0]                  data_in;
    vrc6_cpu_pkg::prg_bank_t     prg_mask;
    logic [`VRC6_CHR_BANK_W-2:0] chr_mask;
    vrc6_cpu_pkg::prg_bank_t     prg_addr;
    logic [`VRC6_CHR_BANK_W:0]   chr_addr;
    logic                        ciram_ce;
    logic                        irq;
    vrc6_audio_pkg::mix_level_t  audio_level;

    // expectations, each with its own enable
    logic                        irq_chk;
    logic                        exp_irq;
    logic                        prg_chk;
    vrc6_cpu_pkg::prg_bank_t     exp_prg;
    logic                        chr_chk;
    logic [`VRC6_CHR_BANK_W:0]   exp_chr;
    logic                        nt_chk;
    logic                        exp_nt;
    logic                        exp_ciram;
    logic                        aud_chk;
    vrc6_audio_pkg::mix_level_t  exp_audio;
    logic                        saw_chk;
    vrc6_audio_pkg::mix_level_t  saw_max;
    int                          since_zero;
    int                          errors;
    int                          checks;
    int                          tests;

    vrc6_mapper UUT (
        .clk20, .reset, .ce, .prg_we, .swap_a01, .prg_a, .chr_a, .data_in,
        .prg_mask, .chr_mask, .prg_addr, .chr_addr, .ciram_ce, .irq, .audio_level
    );

    always #(CLK_PERIOD / 2) clk20 = ~clk20;

    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired at %0t, tests did not finish in time", $time);
        $display("Checks failed");
        $finish;
    end

    always @(posedge clk20) begin
        if (!reset) begin
            checks += int'(irq_chk) + int'(prg_chk) + int'(chr_chk) + int'(nt_chk)
                    + int'(aud_chk) + int'(saw_chk);
        end
    end

    // cycles with a nonzero level since the last zero
    always @(posedge clk20 or posedge reset) begin
        if (reset) begin
            since_zero <= 0;
        end else if (audio_level == '0) begin
            since_zero <= 0;
        end else begin
            since_zero <= since_zero + 1;
        end
    end

    a_irq: assert property (@(posedge clk20) disable iff (reset) irq_chk |-> irq == exp_irq)
        else begin
            errors++;
            $display("Mismatch at %0t: irq expected %b, got %b",
                     $time, $sampled(exp_irq), $sampled(irq));
        end

    a_prg: assert property (@(posedge clk20) disable iff (reset)
        prg_chk |-> prg_addr == exp_prg)
        else begin
            errors++;
            $display("Mismatch at %0t: prg_addr expected %h, got %h",
                     $time, $sampled(exp_prg), $sampled(prg_addr));
        end

    a_chr: assert property (@(posedge clk20) disable iff (reset)
        chr_chk |-> chr_addr == exp_chr)
        else begin
            errors++;
            $display("Mismatch at %0t: chr_addr expected %h, got %h",
                     $time, $sampled(exp_chr), $sampled(chr_addr));
        end

    a_ciram: assert property (@(posedge clk20) disable iff (reset)
        (chr_chk || nt_chk) |-> ciram_ce == exp_ciram)
        else begin
            errors++;
            $display("Mismatch at %0t: ciram_ce expected %b, got %b",
                     $time, $sampled(exp_ciram), $sampled(ciram_ce));
        end

    a_nt: assert property (@(posedge clk20) disable iff (reset)
        nt_chk |-> chr_addr[0] == exp_nt)
        else begin
            errors++;
            $display("Mismatch at %0t: chr_addr[0] expected %b, got %b",
                     $time, $sampled(exp_nt), $sampled(chr_addr[0]));
        end

    a_audio: assert property (@(posedge clk20) disable iff (reset)
        aud_chk |-> audio_level == exp_audio)
        else begin
            errors++;
            $display("Mismatch at %0t: audio_level expected %0d, got %0d",
                     $time, $sampled(exp_audio), $sampled(audio_level));
        end

    a_saw_max: assert property (@(posedge clk20) disable iff (reset)
        saw_chk |-> audio_level <= saw_max)
        else begin
            errors++;
            $display("Mismatch at %0t: audio_level expected at most %0d, got %0d",
                     $time, $sampled(saw_max), $sampled(audio_level));
        end

    a_saw_zero: assert property (@(posedge clk20) disable iff (reset)
        saw_chk |-> since_zero <= ZERO_GAP)
        else begin
            errors++;
            $display("at %0t the saw level stayed above zero for %0d cycles",
                     $time, $sampled(since_zero));
        end

    function automatic vrc6_cpu_pkg::prg_bank_t expected_prg(input logic [15:0] a,
                                                            input logic [7:0] r8000,
                                                            input logic [7:0] rc000,
                                                            input vrc6_cpu_pkg::prg_bank_t mask);
        vrc6_cpu_pkg::prg_bank_t bank;
        if (a < 16'h8000) begin
            bank = '0;
        end else if (a < 16'hc000) begin
            bank = {r8000[`VRC6_PRG_BANK_W-2:0], a[13]};  // 16 KiB window
        end else if (a < 16'he000) begin
            bank = rc000[`VRC6_PRG_BANK_W-1:0];
        end else begin
            bank = '1;
        end
        return bank & mask;
    endfunction

    function automatic logic expected_nt(input logic [1:0] mode, input logic [13:0] a);
        case (mode)
            2'd0:    return a[10];  // vertical
            2'd1:    return a[11];  // horizontal
            2'd2:    return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk20);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        prg_a   = addr;
        data_in = data;
        prg_we  = 1'b1;
        next_cycle();
        prg_we  = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("%0t: test %s finished, %0d new errors", $time, name, errors - errors_before);
    endtask

    task automatic reset_state();
        exp_irq   = 1'b0;
        irq_chk   = 1'b1;
        exp_audio = '0;
        aud_chk   = 1'b1;
        wait_cycles(4);
        aud_chk   = 1'b0;
    endtask

    task automatic prg_mapping();
        logic [7:0]  r8000;
        logic [7:0]  rc000;
        logic [15:0] base;
        int          round;
        int          region;
        int          k;
        for (round = 0; round < 4; round++) begin
            r8000    = 8'($urandom);
            rc000    = 8'($urandom);
            prg_mask = vrc6_cpu_pkg::prg_bank_t'($urandom);
            write_reg(16'h8000 | 16'($urandom_range(3)), r8000);
            write_reg(16'hc000 | 16'($urandom_range(3)), rc000);
            for (region = 0; region < 5; region++) begin
                base = 16'h6000 + 16'(region) * 16'h2000;
                for (k = 0; k < 3; k++) begin
                    prg_a   = base | 16'($urandom_range(16'h1fff));
                    exp_prg = expected_prg(prg_a, r8000, rc000, prg_mask);
                    prg_chk = 1'b1;
                    next_cycle();
                end
            end
            prg_chk = 1'b0;
        end
    endtask

    // one pass of bank writes plus all four mirror modes
    task automatic chr_mirroring(input logic swap);
        logic [7:0]  val [8];
        logic [1:0]  off;
        logic [15:0] addr;
        logic [13:0] a;
        int          i;
        int          mode;
        swap_a01 = swap;
        for (i = 0; i < 8; i++) begin
            val[i] = 8'($urandom);
            off    = 2'(i);
            addr   = (i < 4) ? 16'hd000 : 16'he000;
            addr   = addr | (swap ? {off[0], off[1]} : off);  // mapper 26 crosses A0/A1
            write_reg(addr, val[i]);
        end
        for (mode = 0; mode < 4; mode++) begin
            write_reg(16'hb003, {4'h0, 2'(mode), 2'b00});
            for (i = 0; i < 8; i++) begin
                a         = {1'b0, 3'(i), 10'($urandom)};
                chr_a     = a;
                exp_chr   = 9'(val[i]) & {chr_mask, 2'b11};  // mask from 4 KiB up
                exp_ciram = 1'b0;
                chr_chk   = 1'b1;
                next_cycle();
            end
            chr_chk = 1'b0;
            for (i = 0; i < 4; i++) begin
                a         = {1'b1, 13'($urandom)};
                chr_a     = a;
                exp_nt    = expected_nt(2'(mode), a);
                exp_ciram = 1'b1;
                nt_chk    = 1'b1;
                next_cycle();
            end
            nt_chk = 1'b0;
        end
        swap_a01 = 1'b0;
    endtask

    task automatic cycle_irq();
        logic [7:0] latch;
        int         n;
        latch = 8'($urandom_range(200));
        n     = 256 - int'(latch);
        write_reg(16'hf000, latch);
        write_reg(16'hf001, 8'h07);  // cycle mode, enable, enable after ack
        exp_irq = 1'b0;
        wait_cycles(n);
        exp_irq = 1'b1;
        next_cycle();
        write_reg(16'hf002, 8'h00);
        exp_irq = 1'b0;
        // counter reloaded at the first overflow, next one n ticks after it
        wait_cycles(n - 2);
        exp_irq = 1'b1;
        next_cycle();
        write_reg(16'hf001, 8'h00);
        exp_irq = 1'b0;
        wait_cycles(2);
    endtask

    task automatic expect_audio(input vrc6_audio_pkg::mix_level_t level);
        wait_cycles(3);  // enable edge, then the registered level
        exp_audio = level;
        aud_chk   = 1'b1;
        wait_cycles(16);
        aud_chk   = 1'b0;
    endtask

    task automatic pulse_levels();
        vrc6_audio_pkg::pulse_level_t v0;
        vrc6_audio_pkg::pulse_level_t v1;
        v0 = 4'($urandom_range(15, 1));
        v1 = 4'($urandom_range(15, 1));
        write_reg(16'h9000, {1'b1, 3'($urandom), v0});  // mode 1 ignores duty
        write_reg(16'h9001, 8'($urandom));
        write_reg(16'h9002, {4'h8, 4'($urandom)});
        write_reg(16'ha000, {1'b1, 3'($urandom), v1});
        write_reg(16'ha001, 8'($urandom));
        write_reg(16'ha002, {4'h8, 4'($urandom)});
        expect_audio(vrc6_audio_pkg::mix_level_t'(v0) + vrc6_audio_pkg::mix_level_t'(v1));
        write_reg(16'ha002, 8'h00);
        expect_audio(vrc6_audio_pkg::mix_level_t'(v0));
        write_reg(16'h9002, 8'h00);
        expect_audio('0);
    endtask

    task automatic saw_bound();
        logic [5:0] rate;
        rate    = 6'($urandom_range(63, 1));
        saw_max = vrc6_audio_pkg::mix_level_t'((6 * int'(rate)) >> 3);
        saw_chk = 1'b1;
        write_reg(16'hb000, {2'b00, rate});
        write_reg(16'hb001, 8'h00);
        write_reg(16'hb002, 8'h80);
        wait_cycles(120);
        saw_chk = 1'b0;
        write_reg(16'hb002, 8'h00);
    endtask

    initial begin : main
        int err_mark;
        void'($urandom(SEED));
        clk20     = 1'b0;
        reset     = 1'b1;
        ce        = 1'b1;
        prg_we    = 1'b0;
        swap_a01  = 1'b0;
        prg_a     = 16'h0000;
        chr_a     = 14'h0000;
        data_in   = 8'h00;
        prg_mask  = '1;
        chr_mask  = '1;
        irq_chk   = 1'b0;
        exp_irq   = 1'b0;
        prg_chk   = 1'b0;
        exp_prg   = '0;
        chr_chk   = 1'b0;
        exp_chr   = '0;
        nt_chk    = 1'b0;
        exp_nt    = 1'b0;
        exp_ciram = 1'b0;
        aud_chk   = 1'b0;
        exp_audio = '0;
        saw_chk   = 1'b0;
        saw_max   = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (2) @(posedge clk20);
        #1;
        reset = 1'b0;

        err_mark = errors;
        reset_state();
        report_test("reset_state", err_mark);
        err_mark = errors;
        prg_mapping();
        report_test("prg_mapping", err_mark);
        err_mark = errors;
        chr_mask = 7'($urandom);
        chr_mirroring(1'b0);
        chr_mirroring(1'b1);
        report_test("chr_mirroring", err_mark);
        err_mark = errors;
        cycle_irq();
        report_test("cycle_irq", err_mark);
        err_mark = errors;
        pulse_levels();
        report_test("pulse_levels", err_mark);
        err_mark = errors;
        saw_bound();
        report_test("saw_bound", err_mark);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/vrc6_cpu_pkg.sv
design/vrc6_audio_pkg.sv
design/vrc6_banking.sv
design/vrc6_irq.sv
design/vrc6_pulse.sv
design/vrc6_saw.sv
design/vrc6_mapper.sv
dv/vrc6_tb.sv

// File: Bender.yml
package:
  name: vrc6_mapper

sources:
  - include_dirs:
      - design
    files:
      - design/vrc6_cpu_pkg.sv
      - design/vrc6_audio_pkg.sv
      - design/vrc6_banking.sv
      - design/vrc6_irq.sv
      - design/vrc6_pulse.sv
      - design/vrc6_saw.sv
      - design/vrc6_mapper.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/vrc6_tb.sv
